// ==== hw/vex_macros.svh ====
`ifndef VEX_MACROS_SVH
`define VEX_MACROS_SVH

// element and scalar register width
`define VEX_XLEN 32

// scalar register select
`define VEX_RSEL_W 5

// element-pair offset within a vector
`define VEX_WOFF_W 4

// unit stride for consecutive 32-bit elements
`define VEX_UNIT_STRIDE 32'd4

`endif

// ==== hw/vex_isa_pkg.sv ====
package vex_isa_pkg;

  // where an ALU operand comes from
  typedef enum logic [1:0] {
    V = 2'd0,
    I = 2'd1,
    X = 2'd2
  } src_t;

  // lane ALU operations, MIN and MAX are signed
  typedef enum logic [3:0] {
    ADD = 4'd0,
    SUB = 4'd1,
    AND = 4'd2,
    OR  = 4'd3,
    XOR = 4'd4,
    SLL = 4'd5,
    SRL = 4'd6,
    MIN = 4'd7,
    MAX = 4'd8
  } aluop_t;

  // instruction class decides what the result means
  typedef enum logic [1:0] {
    ARITH  = 2'd0,
    LOAD   = 2'd1,
    STORE  = 2'd2,
    CONFIG = 2'd3
  } iclass_t;

endpackage

// ==== hw/vex_pipe_pkg.sv ====
`include "vex_macros.svh"

package vex_pipe_pkg;

  // decoded instruction as held in the execute register
  typedef struct packed {
    vex_isa_pkg::iclass_t     iclass;
    vex_isa_pkg::aluop_t      aluop;
    vex_isa_pkg::src_t        src1;
    vex_isa_pkg::src_t        src2;
    logic [`VEX_XLEN-1:0]     vs1_lane0;
    logic [`VEX_XLEN-1:0]     vs1_lane1;
    logic [`VEX_XLEN-1:0]     vs2_lane0;
    logic [`VEX_XLEN-1:0]     vs2_lane1;
    logic [`VEX_XLEN-1:0]     xs1;
    logic [`VEX_XLEN-1:0]     xs2;
    logic [`VEX_XLEN-1:0]     imm;
    logic                     mask0;
    logic                     mask1;
    logic [`VEX_WOFF_W-1:0]   woffset;
    logic                     stride_type;
    logic [`VEX_XLEN-1:0]     stride_val;
    logic                     indexed;
    logic [`VEX_XLEN-1:0]     storedata0;
    logic [`VEX_XLEN-1:0]     storedata1;
    logic [`VEX_RSEL_W-1:0]   rd_sel;
    logic [`VEX_XLEN-1:0]     vl;
  } ex_bundle_t;

  // results handed on to the memory stage
  typedef struct packed {
    logic                     load;
    logic                     store;
    logic [`VEX_XLEN-1:0]     result0;
    logic [`VEX_XLEN-1:0]     result1;
    logic [`VEX_XLEN-1:0]     storedata0;
    logic [`VEX_XLEN-1:0]     storedata1;
    logic                     wen0;
    logic                     wen1;
    logic [`VEX_WOFF_W-1:0]   woffset;
    logic                     config_type;
    logic [`VEX_XLEN-1:0]     vl;
  } mem_bundle_t;

endpackage

// ==== hw/stage_latch.sv ====
module stage_latch #(
  parameter type payload_t = logic
) (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     load,
  input  logic     flush,
  input  logic     d_valid,
  input  payload_t d,
  output logic     q_valid,
  output payload_t q
);

  // flush wins over load so a squashed slot never carries stale data
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      q_valid <= 1'b0;
      q       <= '0;
    end else if (flush) begin
      q_valid <= 1'b0;
      q       <= '0;
    end else if (load) begin
      q_valid <= d_valid;
      q       <= d;
    end
  end

  // held slot must not drift while neither loading nor flushing
  a_hold_stable: assert property (
    @(posedge CLK) disable iff (!nRST)
    (!load && !flush) |=> ($stable(q_valid) && $stable(q))
  ) else $error("stage_latch: contents changed without load or flush");

endmodule

// ==== hw/vex_issue_port.sv ====
`include "vex_macros.svh"

module vex_issue_port (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      req,
  output logic                      ack,
  input  vex_isa_pkg::iclass_t      iclass,
  input  vex_isa_pkg::aluop_t       aluop,
  input  vex_isa_pkg::src_t         src1,
  input  vex_isa_pkg::src_t         src2,
  input  logic [`VEX_XLEN-1:0]      vs1_lane0,
  input  logic [`VEX_XLEN-1:0]      vs1_lane1,
  input  logic [`VEX_XLEN-1:0]      vs2_lane0,
  input  logic [`VEX_XLEN-1:0]      vs2_lane1,
  input  logic [`VEX_XLEN-1:0]      xs1,
  input  logic [`VEX_XLEN-1:0]      xs2,
  input  logic [`VEX_XLEN-1:0]      imm,
  input  logic                      mask0,
  input  logic                      mask1,
  input  logic [`VEX_WOFF_W-1:0]    woffset,
  input  logic                      stride_type,
  input  logic [`VEX_XLEN-1:0]      stride_val,
  input  logic                      indexed,
  input  logic [`VEX_XLEN-1:0]      storedata0,
  input  logic [`VEX_XLEN-1:0]      storedata1,
  input  logic [`VEX_RSEL_W-1:0]    rd_sel,
  input  logic [`VEX_XLEN-1:0]      vl,
  input  logic                      advance,
  input  logic                      flush,
  output logic                      ex_valid,
  output vex_pipe_pkg::ex_bundle_t  ex
);

  typedef enum logic {
    IDLE  = 1'b0,
    ACKED = 1'b1
  } hs_state_t;

  hs_state_t                 state;
  logic                      capture;
  vex_pipe_pkg::ex_bundle_t  fields;

  // slot is free when empty or draining this cycle
  assign capture = (state == IDLE) && req && (!ex_valid || advance);
  assign ack     = (state == ACKED);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (capture) state <= ACKED;
        ACKED:   if (!req) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_comb begin
    fields.iclass      = iclass;
    fields.aluop       = aluop;
    fields.src1        = src1;
    fields.src2        = src2;
    fields.vs1_lane0   = vs1_lane0;
    fields.vs1_lane1   = vs1_lane1;
    fields.vs2_lane0   = vs2_lane0;
    fields.vs2_lane1   = vs2_lane1;
    fields.xs1         = xs1;
    fields.xs2         = xs2;
    fields.imm         = imm;
    fields.mask0       = mask0;
    fields.mask1       = mask1;
    fields.woffset     = woffset;
    fields.stride_type = stride_type;
    fields.stride_val  = stride_val;
    fields.indexed     = indexed;
    fields.storedata0  = storedata0;
    fields.storedata1  = storedata1;
    fields.rd_sel      = rd_sel;
    fields.vl          = vl;
  end

  // advance without a capture empties the slot
  stage_latch #(
    .payload_t(vex_pipe_pkg::ex_bundle_t)
  ) i_ex_latch (
    .CLK     (CLK),
    .nRST    (nRST),
    .load    (capture || advance),
    .flush   (flush),
    .d_valid (capture),
    .d       (fields),
    .q_valid (ex_valid),
    .q       (ex)
  );

  a_ack_after_req: assert property (
    @(posedge CLK) disable iff (!nRST)
    $rose(ack) |-> $past(req)
  ) else $error("vex_issue_port: ack rose without a pending req");

endmodule

// ==== hw/vector_lane.sv ====
`include "vex_macros.svh"

module vector_lane (
  input  vex_isa_pkg::src_t     src1,
  input  vex_isa_pkg::src_t     src2,
  input  vex_isa_pkg::aluop_t   aluop,
  input  logic [`VEX_XLEN-1:0]  vs1,
  input  logic [`VEX_XLEN-1:0]  vs2,
  input  logic [`VEX_XLEN-1:0]  xs1,
  input  logic [`VEX_XLEN-1:0]  xs2,
  input  logic [`VEX_XLEN-1:0]  imm,
  input  logic                  mask,
  input  logic                  vec_write,
  input  logic [`VEX_XLEN-1:0]  addr_base,
  input  logic [`VEX_XLEN-1:0]  addr_step,
  output logic [`VEX_XLEN-1:0]  result,
  output logic                  wen,
  output logic [`VEX_XLEN-1:0]  addr
);

  logic [`VEX_XLEN-1:0] op_a;
  logic [`VEX_XLEN-1:0] op_b;
  logic                 a_lt_b;

  // operand a
  always_comb begin
    case (src1)
      vex_isa_pkg::V: op_a = vs1;
      vex_isa_pkg::I: op_a = imm;
      vex_isa_pkg::X: op_a = xs1;
      default:        op_a = '0;
    endcase
  end

  // operand b
  always_comb begin
    case (src2)
      vex_isa_pkg::V: op_b = vs2;
      vex_isa_pkg::I: op_b = imm;
      vex_isa_pkg::X: op_b = xs2;
      default:        op_b = '0;
    endcase
  end

  assign a_lt_b = $signed(op_a) < $signed(op_b);

  always_comb begin
    case (aluop)
      vex_isa_pkg::ADD: result = op_a + op_b;
      vex_isa_pkg::SUB: result = op_a - op_b;
      vex_isa_pkg::AND: result = op_a & op_b;
      vex_isa_pkg::OR:  result = op_a | op_b;
      vex_isa_pkg::XOR: result = op_a ^ op_b;
      // shift amount from low bits only
      vex_isa_pkg::SLL: result = op_a << op_b[4:0];
      vex_isa_pkg::SRL: result = op_a >> op_b[4:0];
      vex_isa_pkg::MIN: result = a_lt_b ? op_a : op_b;
      vex_isa_pkg::MAX: result = a_lt_b ? op_b : op_a;
      default:          result = '0;
    endcase
  end

  // masked-off elements keep their old value
  assign wen  = vec_write && mask;
  assign addr = addr_base + addr_step;

  always_comb begin
    a_mask_gates_wen: assert (!wen || mask)
      else $error("vector_lane: element write with mask low");
  end

endmodule

// ==== hw/vector_execute_stage.sv ====
`include "vex_macros.svh"

module vector_execute_stage (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       ex_valid,
  input  vex_pipe_pkg::ex_bundle_t   ex,
  input  logic                       mem_stall,
  input  logic                       flush,
  output logic                       advance,
  output logic                       rd_wen,
  output logic [`VEX_RSEL_W-1:0]     rd_sel,
  output logic [`VEX_XLEN-1:0]       rd_data,
  output logic                       mem_valid,
  output vex_pipe_pkg::mem_bundle_t  mem
);

  logic [`VEX_XLEN-1:0]       stride;
  logic [`VEX_XLEN-1:0]       addr_buffer;
  logic [`VEX_XLEN-1:0]       base0, step0, base1, step1;
  logic [`VEX_XLEN-1:0]       result0, result1;
  logic [`VEX_XLEN-1:0]       addr0, addr1;
  logic                       wen0, wen1;
  logic                       is_arith, is_load, is_store, is_mem, first_pair;
  vex_pipe_pkg::mem_bundle_t  mem_d;

  assign is_arith = ex_valid && (ex.iclass == vex_isa_pkg::ARITH);
  assign is_load  = ex_valid && (ex.iclass == vex_isa_pkg::LOAD);
  assign is_store = ex_valid && (ex.iclass == vex_isa_pkg::STORE);
  assign is_mem   = is_load || is_store;
  assign advance  = ex_valid && !mem_stall;

  assign stride     = ex.stride_type ? ex.stride_val : `VEX_UNIT_STRIDE;
  assign first_pair = (ex.woffset == '0);

  // lane 0 restarts at the base on the first pair, else chains from the buffer
  assign base0 = (ex.indexed || first_pair) ? ex.xs1 : addr_buffer;
  assign step0 = ex.indexed ? ex.vs2_lane0 : (first_pair ? '0 : stride);
  // lane 1 steps once past lane 0
  assign base1 = ex.indexed ? ex.xs1 : addr0;
  assign step1 = ex.indexed ? ex.vs2_lane1 : stride;

  vector_lane i_lane0 (
    .src1      (ex.src1),
    .src2      (ex.src2),
    .aluop     (ex.aluop),
    .vs1       (ex.vs1_lane0),
    .vs2       (ex.vs2_lane0),
    .xs1       (ex.xs1),
    .xs2       (ex.xs2),
    .imm       (ex.imm),
    .mask      (ex.mask0),
    .vec_write (is_arith),
    .addr_base (base0),
    .addr_step (step0),
    .result    (result0),
    .wen       (wen0),
    .addr      (addr0)
  );

  vector_lane i_lane1 (
    .src1      (ex.src1),
    .src2      (ex.src2),
    .aluop     (ex.aluop),
    .vs1       (ex.vs1_lane1),
    .vs2       (ex.vs2_lane1),
    .xs1       (ex.xs1),
    .xs2       (ex.xs2),
    .imm       (ex.imm),
    .mask      (ex.mask1),
    .vec_write (is_arith),
    .addr_base (base1),
    .addr_step (step1),
    .result    (result1),
    .wen       (wen1),
    .addr      (addr1)
  );

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      addr_buffer <= '0;
    end else if (advance && is_mem) begin
      addr_buffer <= addr1;
    end
  end

  // vsetvl-style writeback of the granted length
  assign rd_wen  = ex_valid && (ex.iclass == vex_isa_pkg::CONFIG);
  assign rd_sel  = ex.rd_sel;
  assign rd_data = ex.vl;

  always_comb begin
    mem_d.load        = is_load;
    mem_d.store       = is_store;
    mem_d.result0     = is_mem ? addr0 : result0;
    mem_d.result1     = is_mem ? addr1 : result1;
    mem_d.storedata0  = ex.storedata0;
    mem_d.storedata1  = ex.storedata1;
    mem_d.wen0        = wen0;
    mem_d.wen1        = wen1;
    mem_d.woffset     = ex.woffset;
    mem_d.config_type = rd_wen;
    mem_d.vl          = ex.vl;
  end

  stage_latch #(
    .payload_t(vex_pipe_pkg::mem_bundle_t)
  ) i_mem_latch (
    .CLK     (CLK),
    .nRST    (nRST),
    .load    (!mem_stall),
    .flush   (flush),
    .d_valid (ex_valid),
    .d       (mem_d),
    .q_valid (mem_valid),
    .q       (mem)
  );

  a_advance_to_mem: assert property (
    @(posedge CLK) disable iff (!nRST)
    (advance && !flush) |=> mem_valid
  ) else $error("vector_execute_stage: advanced instruction missing in memory latch");

endmodule

// ==== hw/vector_execute_unit.sv ====
`include "vex_macros.svh"

module vector_execute_unit (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    req,
  output logic                    ack,
  input  vex_isa_pkg::iclass_t    iclass,
  input  vex_isa_pkg::aluop_t     aluop,
  input  vex_isa_pkg::src_t       src1,
  input  vex_isa_pkg::src_t       src2,
  input  logic [`VEX_XLEN-1:0]    vs1_lane0,
  input  logic [`VEX_XLEN-1:0]    vs1_lane1,
  input  logic [`VEX_XLEN-1:0]    vs2_lane0,
  input  logic [`VEX_XLEN-1:0]    vs2_lane1,
  input  logic [`VEX_XLEN-1:0]    xs1,
  input  logic [`VEX_XLEN-1:0]    xs2,
  input  logic [`VEX_XLEN-1:0]    imm,
  input  logic                    mask0,
  input  logic                    mask1,
  input  logic [`VEX_WOFF_W-1:0]  woffset,
  input  logic                    stride_type,
  input  logic [`VEX_XLEN-1:0]    stride_val,
  input  logic                    indexed,
  input  logic [`VEX_XLEN-1:0]    storedata0,
  input  logic [`VEX_XLEN-1:0]    storedata1,
  input  logic [`VEX_RSEL_W-1:0]  rd_sel,
  input  logic [`VEX_XLEN-1:0]    vl,
  input  logic                    mem_stall,
  input  logic                    flush,
  output logic                    rd_wen,
  output logic [`VEX_RSEL_W-1:0]  wb_sel,
  output logic [`VEX_XLEN-1:0]    rd_data,
  output logic                    mem_valid,
  output logic                    mem_load,
  output logic                    mem_store,
  output logic [`VEX_XLEN-1:0]    mem_result0,
  output logic [`VEX_XLEN-1:0]    mem_result1,
  output logic [`VEX_XLEN-1:0]    mem_storedata0,
  output logic [`VEX_XLEN-1:0]    mem_storedata1,
  output logic                    mem_wen0,
  output logic                    mem_wen1,
  output logic [`VEX_WOFF_W-1:0]  mem_woffset,
  output logic                    mem_config,
  output logic [`VEX_XLEN-1:0]    mem_vl
);

  logic                       advance;
  logic                       ex_valid;
  vex_pipe_pkg::ex_bundle_t   ex;
  vex_pipe_pkg::mem_bundle_t  mem;

  vex_issue_port i_issue_port (
    .CLK         (CLK),
    .nRST        (nRST),
    .req         (req),
    .ack         (ack),
    .iclass      (iclass),
    .aluop       (aluop),
    .src1        (src1),
    .src2        (src2),
    .vs1_lane0   (vs1_lane0),
    .vs1_lane1   (vs1_lane1),
    .vs2_lane0   (vs2_lane0),
    .vs2_lane1   (vs2_lane1),
    .xs1         (xs1),
    .xs2         (xs2),
    .imm         (imm),
    .mask0       (mask0),
    .mask1       (mask1),
    .woffset     (woffset),
    .stride_type (stride_type),
    .stride_val  (stride_val),
    .indexed     (indexed),
    .storedata0  (storedata0),
    .storedata1  (storedata1),
    .rd_sel      (rd_sel),
    .vl          (vl),
    .advance     (advance),
    .flush       (flush),
    .ex_valid    (ex_valid),
    .ex          (ex)
  );

  // rd_sel out of execute is the held copy, not the requester's field
  vector_execute_stage i_execute_stage (
    .CLK       (CLK),
    .nRST      (nRST),
    .ex_valid  (ex_valid),
    .ex        (ex),
    .mem_stall (mem_stall),
    .flush     (flush),
    .advance   (advance),
    .rd_wen    (rd_wen),
    .rd_sel    (wb_sel),
    .rd_data   (rd_data),
    .mem_valid (mem_valid),
    .mem       (mem)
  );

  assign mem_load       = mem.load;
  assign mem_store      = mem.store;
  assign mem_result0    = mem.result0;
  assign mem_result1    = mem.result1;
  assign mem_storedata0 = mem.storedata0;
  assign mem_storedata1 = mem.storedata1;
  assign mem_wen0       = mem.wen0;
  assign mem_wen1       = mem.wen1;
  assign mem_woffset    = mem.woffset;
  assign mem_config     = mem.config_type;
  assign mem_vl         = mem.vl;

endmodule

// ==== tb/vector_execute_tb.sv ====
`include "vex_macros.svh"

module vector_execute_tb;

  timeunit 1ns;
  timeprecision 1ps;

  // about 100 instructions at 6 cycles or fewer, plus reset and drains
  localparam int TIMEOUT_CYCLES = 1000;

  logic                       CLK;
  logic                       nRST;
  logic                       req;
  logic                       ack;
  vex_isa_pkg::iclass_t       iclass;
  vex_isa_pkg::aluop_t        aluop;
  vex_isa_pkg::src_t          src1;
  vex_isa_pkg::src_t          src2;
  logic [`VEX_XLEN-1:0]       vs1_lane0;
  logic [`VEX_XLEN-1:0]       vs1_lane1;
  logic [`VEX_XLEN-1:0]       vs2_lane0;
  logic [`VEX_XLEN-1:0]       vs2_lane1;
  logic [`VEX_XLEN-1:0]       xs1;
  logic [`VEX_XLEN-1:0]       xs2;
  logic [`VEX_XLEN-1:0]       imm;
  logic                       mask0;
  logic                       mask1;
  logic [`VEX_WOFF_W-1:0]     woffset;
  logic                       stride_type;
  logic [`VEX_XLEN-1:0]       stride_val;
  logic                       indexed;
  logic [`VEX_XLEN-1:0]       storedata0;
  logic [`VEX_XLEN-1:0]       storedata1;
  logic [`VEX_RSEL_W-1:0]     rd_sel;
  logic [`VEX_XLEN-1:0]       vl;
  logic                       mem_stall;
  logic                       flush;
  logic                       rd_wen;
  logic [`VEX_RSEL_W-1:0]     wb_sel;
  logic [`VEX_XLEN-1:0]       rd_data;
  logic                       mem_valid;
  logic                       mem_load;
  logic                       mem_store;
  logic [`VEX_XLEN-1:0]       mem_result0;
  logic [`VEX_XLEN-1:0]       mem_result1;
  logic [`VEX_XLEN-1:0]       mem_storedata0;
  logic [`VEX_XLEN-1:0]       mem_storedata1;
  logic                       mem_wen0;
  logic                       mem_wen1;
  logic [`VEX_WOFF_W-1:0]     mem_woffset;
  logic                       mem_config;
  logic [`VEX_XLEN-1:0]       mem_vl;

  logic [31:0]                lcg_state;
  int                         errors = 0;
  int                         checked = 0;
  int                         cycles = 0;
  string                      test_name;
  logic                       mem_loaded;
  logic [`VEX_XLEN-1:0]       model_buf;
  vex_pipe_pkg::mem_bundle_t  exp_q[$];
  vex_pipe_pkg::mem_bundle_t  exp_mem;

  vector_execute_unit i_vector_execute_unit (.*);

  initial CLK = 1'b0;
  always #20 CLK = ~CLK;

  task automatic report_mismatch(input string field, input logic [31:0] expv,
                                 input logic [31:0] actv);
    $display("** Error: %s: %s expected %h, actual %h", test_name, field, expv, actv);
    errors++;
  endtask

  task automatic flag_failure(input string what);
    $display("%s: %s", test_name, what);
    errors++;
  endtask

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [`VEX_XLEN-1:0] pick_operand(input vex_isa_pkg::src_t s,
                                                        input logic [`VEX_XLEN-1:0] vec,
                                                        input logic [`VEX_XLEN-1:0] imm_v,
                                                        input logic [`VEX_XLEN-1:0] scalar);
    case (s)
      vex_isa_pkg::V: return vec;
      vex_isa_pkg::I: return imm_v;
      vex_isa_pkg::X: return scalar;
      default:        return '0;
    endcase
  endfunction

  function automatic logic [`VEX_XLEN-1:0] ref_alu(input vex_isa_pkg::aluop_t op,
                                                   input logic [`VEX_XLEN-1:0] a,
                                                   input logic [`VEX_XLEN-1:0] b);
    case (op)
      vex_isa_pkg::ADD: return a + b;
      vex_isa_pkg::SUB: return a - b;
      vex_isa_pkg::AND: return a & b;
      vex_isa_pkg::OR:  return a | b;
      vex_isa_pkg::XOR: return a ^ b;
      vex_isa_pkg::SLL: return a << b[4:0];
      vex_isa_pkg::SRL: return a >> b[4:0];
      vex_isa_pkg::MIN: return ($signed(a) < $signed(b)) ? a : b;
      vex_isa_pkg::MAX: return ($signed(a) < $signed(b)) ? b : a;
      default:          return '0;
    endcase
  endfunction

  // expected memory bundle for the fields on the issue port
  task automatic push_expected();
    vex_pipe_pkg::mem_bundle_t e;
    logic [`VEX_XLEN-1:0]      stride;
    logic [`VEX_XLEN-1:0]      a0;
    logic [`VEX_XLEN-1:0]      a1;
    logic                      is_mem;
    is_mem = (iclass == vex_isa_pkg::LOAD) || (iclass == vex_isa_pkg::STORE);
    stride = stride_type ? stride_val : 32'd4;
    if (indexed) begin
      a0 = xs1 + vs2_lane0;
      a1 = xs1 + vs2_lane1;
    end else begin
      a0 = (woffset == '0) ? xs1 : model_buf + stride;
      a1 = a0 + stride;
    end
    if (is_mem) begin
      model_buf = a1;
    end
    e.load        = (iclass == vex_isa_pkg::LOAD);
    e.store       = (iclass == vex_isa_pkg::STORE);
    e.result0     = is_mem ? a0 : ref_alu(aluop, pick_operand(src1, vs1_lane0, imm, xs1),
                                          pick_operand(src2, vs2_lane0, imm, xs2));
    e.result1     = is_mem ? a1 : ref_alu(aluop, pick_operand(src1, vs1_lane1, imm, xs1),
                                          pick_operand(src2, vs2_lane1, imm, xs2));
    e.storedata0  = storedata0;
    e.storedata1  = storedata1;
    e.wen0        = (iclass == vex_isa_pkg::ARITH) && mask0;
    e.wen1        = (iclass == vex_isa_pkg::ARITH) && mask1;
    e.woffset     = woffset;
    e.config_type = (iclass == vex_isa_pkg::CONFIG);
    e.vl          = vl;
    exp_q.push_back(e);
  endtask

  task automatic randomize_fields();
    logic [31:0] r;
    vs1_lane0  = next_rand();
    vs1_lane1  = next_rand();
    vs2_lane0  = next_rand();
    vs2_lane1  = next_rand();
    xs1        = next_rand();
    xs2        = next_rand();
    imm        = next_rand();
    storedata0 = next_rand();
    storedata1 = next_rand();
    vl         = next_rand();
    r = next_rand();
    mask0       = r[0];
    mask1       = r[1];
    stride_type = r[2];
    indexed     = r[3];
    woffset     = r[7:4];
    rd_sel      = r[12:8];
    stride_val  = {24'd0, r[23:18], 2'b00};
    iclass = vex_isa_pkg::ARITH;
    aluop  = vex_isa_pkg::ADD;
    src1   = vex_isa_pkg::V;
    src2   = vex_isa_pkg::V;
  endtask

  task automatic wait_for_ack();
    do begin
      @(posedge CLK);
      #1;
    end while (!ack);
  endtask

  // drop req and wait for the port to drop ack
  task automatic release_req();
    req = 1'b0;
    do begin
      @(posedge CLK);
      #1;
    end while (ack);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge CLK);
      #1;
    end
  endtask

  // one full four-phase transfer, keep low for an instruction that gets flushed
  task automatic send(input logic keep);
    if (keep) begin
      push_expected();
    end
    req = 1'b1;
    wait_for_ack();
    // requester lingers a cycle so ack has to outlast req
    idle_cycles(1);
    release_req();
  endtask

  task automatic arith_sweep();
    test_name = "arith";
    for (int op = 0; op < 9; op++) begin
      for (int s1 = 0; s1 < 3; s1++) begin
        for (int s2 = 0; s2 < 3; s2++) begin
          randomize_fields();
          aluop = vex_isa_pkg::aluop_t'(4'(op));
          src1  = vex_isa_pkg::src_t'(2'(s1));
          src2  = vex_isa_pkg::src_t'(2'(s2));
          send(1'b1);
        end
      end
    end
  endtask

  task automatic config_writeback();
    test_name = "config";
    repeat (3) begin
      randomize_fields();
      iclass = vex_isa_pkg::CONFIG;
      send(1'b1);
    end
  endtask

  // first pass with an explicit stride, second with unit stride
  task automatic strided_chain();
    logic [31:0] r;
    logic [31:0] step;
    test_name = "strided";
    for (int pass = 0; pass < 2; pass++) begin
      r = next_rand();
      step = {24'd0, r[7:2], 2'b00};
      for (int w = 0; w < 4; w++) begin
        randomize_fields();
        iclass      = (pass == 0) ? vex_isa_pkg::LOAD : vex_isa_pkg::STORE;
        indexed     = 1'b0;
        woffset     = 4'(w);
        stride_type = (pass == 0);
        stride_val  = step;
        send(1'b1);
      end
    end
  endtask

  task automatic indexed_access();
    test_name = "indexed";
    for (int k = 0; k < 4; k++) begin
      randomize_fields();
      iclass  = k[0] ? vex_isa_pkg::STORE : vex_isa_pkg::LOAD;
      indexed = 1'b1;
      send(1'b1);
    end
    // chains from the last indexed lane 1 address
    randomize_fields();
    iclass  = vex_isa_pkg::LOAD;
    indexed = 1'b0;
    woffset = 4'd2;
    send(1'b1);
  endtask

  task automatic stall_hold();
    test_name = "stall";
    randomize_fields();
    send(1'b1);
    mem_stall = 1'b1;
    // execute register is empty, so this one still gets in
    randomize_fields();
    send(1'b1);
    // this one must wait until the stall is released
    randomize_fields();
    push_expected();
    req = 1'b1;
    idle_cycles(4);
    mem_stall = 1'b0;
    wait_for_ack();
    release_req();
  endtask

  // memory latch still holds the last stall instruction when the stall returns
  task automatic flush_drop();
    test_name = "flush";
    mem_stall = 1'b1;
    randomize_fields();
    send(1'b0);
    flush = 1'b1;
    idle_cycles(1);
    flush     = 1'b0;
    mem_stall = 1'b0;
    randomize_fields();
    send(1'b1);
  endtask

  always @(posedge CLK) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles, %0d errors so far",
               TIMEOUT_CYCLES, errors);
      $display("Testbench failed");
      $finish;
    end
  end

  // memory latch takes a new value on every edge without stall or flush
  always @(posedge CLK) begin
    mem_loaded <= nRST && !mem_stall && !flush;
  end

  always @(negedge CLK) begin
    if (nRST && mem_valid && mem_loaded) begin
      if (exp_q.size() == 0) begin
        flag_failure("memory stage delivered an instruction that was never issued");
      end else begin
        exp_mem = exp_q.pop_front();
        checked++;
      end
    end
  end

  a_reset_clear: assert property (@(posedge CLK)
    $rose(nRST) |-> (!ack && !mem_valid && !mem_load && !mem_store && !mem_wen0 &&
                     !mem_wen1 && !mem_config && !rd_wen))
    else flag_failure("outputs were not low after reset");

  a_ack_rise: assert property (@(posedge CLK) disable iff (!nRST)
    $rose(ack) |-> $past(req))
    else flag_failure("ack rose while req was low");

  a_ack_fall: assert property (@(posedge CLK) disable iff (!nRST)
    $fell(ack) |-> $past(!req))
    else flag_failure("ack fell while req was still high");

  a_ack_hold: assert property (@(posedge CLK) disable iff (!nRST)
    (ack && req) |=> ack)
    else flag_failure("ack dropped before req fell");

  a_mem_follow: assert property (@(posedge CLK) disable iff (!nRST)
    ($rose(ack) && !mem_stall && !flush) |=> mem_valid)
    else flag_failure("mem_valid did not rise one edge after ack");

  a_no_capture: assert property (@(posedge CLK) disable iff (!nRST)
    (mem_stall && i_vector_execute_unit.ex_valid && !ack) |=> !ack)
    else flag_failure("instruction accepted while the execute register was stalled");

  a_stall_hold: assert property (@(posedge CLK) disable iff (!nRST)
    (mem_stall && !flush) |=> ($stable(mem_valid) && $stable(mem_result0) &&
                               $stable(mem_result1) && $stable(mem_wen0) &&
                               $stable(mem_wen1) && $stable(mem_load) && $stable(mem_store)))
    else flag_failure("memory outputs changed during a stall");

  a_flush_clear: assert property (@(posedge CLK) disable iff (!nRST)
    flush |=> !mem_valid)
    else flag_failure("mem_valid still high after a flush");

  a_cfg_wen: assert property (@(posedge CLK) disable iff (!nRST)
    ($rose(ack) && iclass == vex_isa_pkg::CONFIG) |-> rd_wen)
    else report_mismatch("rd_wen", 32'd1, 32'($sampled(rd_wen)));

  a_cfg_sel: assert property (@(posedge CLK) disable iff (!nRST)
    ($rose(ack) && iclass == vex_isa_pkg::CONFIG) |-> (wb_sel == rd_sel))
    else report_mismatch("rd_sel", 32'($sampled(rd_sel)), 32'($sampled(wb_sel)));

  a_cfg_data: assert property (@(posedge CLK) disable iff (!nRST)
    ($rose(ack) && iclass == vex_isa_pkg::CONFIG) |-> (rd_data == vl))
    else report_mismatch("rd_data", $sampled(vl), $sampled(rd_data));

  a_result0: assert property (@(posedge CLK) disable iff (!nRST)
    mem_valid |-> (mem_result0 == exp_mem.result0))
    else report_mismatch("result0", exp_mem.result0, $sampled(mem_result0));

  a_result1: assert property (@(posedge CLK) disable iff (!nRST)
    mem_valid |-> (mem_result1 == exp_mem.result1))
    else report_mismatch("result1", exp_mem.result1, $sampled(mem_result1));

  a_storedata0: assert property (@(posedge CLK) disable iff (!nRST)
    mem_valid |-> (mem_storedata0 == exp_mem.storedata0))
    else report_mismatch("storedata0", exp_mem.storedata0, $sampled(mem_storedata0));

  a_storedata1: assert property (@(posedge CLK) disable iff (!nRST)
    mem_valid |-> (mem_storedata1 == exp_mem.storedata1))
    else report_mismatch("storedata1", exp_mem.storedata1, $sampled(mem_storedata1));

  a_wen0: assert property (@(posedge CLK) disable iff (!nRST)
    mem_valid |-> (mem_wen0 == exp_mem.wen0))
    else report_mismatch("wen0", 32'(exp_mem.wen0), 32'($sampled(mem_wen0)));

  a_wen1: assert property (@(posedge CLK) disable iff (!nRST)
    mem_valid |-> (mem_wen1 == exp_mem.wen1))
    else report_mismatch("wen1", 32'(exp_mem.wen1), 32'($sampled(mem_wen1)));

  a_kind: assert property (@(posedge CLK) disable iff (!nRST)
    mem_valid |-> ({mem_load, mem_store, mem_config} ==
                   {exp_mem.load, exp_mem.store, exp_mem.config_type}))
    else report_mismatch("load/store/config",
                         32'({exp_mem.load, exp_mem.store, exp_mem.config_type}),
                         32'($sampled({mem_load, mem_store, mem_config})));

  a_woffset: assert property (@(posedge CLK) disable iff (!nRST)
    mem_valid |-> (mem_woffset == exp_mem.woffset))
    else report_mismatch("woffset", 32'(exp_mem.woffset), 32'($sampled(mem_woffset)));

  a_vl: assert property (@(posedge CLK) disable iff (!nRST)
    mem_valid |-> (mem_vl == exp_mem.vl))
    else report_mismatch("vl", exp_mem.vl, $sampled(mem_vl));

  initial begin
    lcg_state = 32'h2e5d2a79;
    test_name = "reset";
    model_buf = '0;
    exp_mem   = '0;
    nRST      = 1'b0;
    req       = 1'b0;
    mem_stall = 1'b0;
    flush     = 1'b0;
    randomize_fields();
    repeat (3) @(posedge CLK);
    #1;
    nRST = 1'b1;
    arith_sweep();
    config_writeback();
    strided_chain();
    indexed_access();
    stall_hold();
    flush_drop();
    idle_cycles(3);
    if (exp_q.size() != 0) begin
      flag_failure("issued instructions never reached the memory stage");
    end
    $display("instructions checked: %0d, errors: %0d", checked, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+hw
hw/vex_isa_pkg.sv
hw/vex_pipe_pkg.sv
hw/stage_latch.sv
hw/vex_issue_port.sv
hw/vector_lane.sv
hw/vector_execute_stage.sv
hw/vector_execute_unit.sv
tb/vector_execute_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the vector execute testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --timescale 1ns/1ps --top-module vector_execute_tb \
  -f filelist.f -o vector_execute_sim \
  && ./obj_dir/vector_execute_sim > sim.log 2>&1 \
  || { echo "build or simulation did not complete, see sim.log"; exit 1; }

grep -q "Testbench failed" sim.log \
  && { echo "simulation failed, see sim.log"; exit 1; } \
  || { echo "simulation passed"; exit 0; }
